//--- design/mm_pkg.sv
package mm_pkg;

    // matrix geometry
    localparam int N_DIM  = 4;                // square matrix dimension
    localparam int DATA_W = 8;                // unsigned operand element
    localparam int ACC_W  = 32;               // accumulator / result word

    // index widths derived from the dimension
    localparam int IDX_W     = (N_DIM > 1) ? $clog2(N_DIM) : 1;  // bank index and bank address
    localparam int RES_ADR_W = $clog2(N_DIM * N_DIM);            // result word address

    // serial receiver states
    typedef enum logic [1:0] {
        IDLE,   // line idle, hunting for a start edge
        START,  // voting on the start bit
        DATA,   // shifting in data bits, lsb first
        STOP    // checking the stop bit
    } rx_state_t;

    // job sequencing in the loader
    typedef enum logic [1:0] {
        LOAD_A,   // bytes 0..N*N-1, matrix a row-major
        LOAD_B,   // next N*N bytes, matrix b row-major
        COMPUTE,  // array is running, waiting for the drain
        DONE      // results final until the next byte
    } job_state_t;

endpackage

//--- design/uart_rx.sv
module uart_rx import mm_pkg::*; #(
    parameter int CLKS_PER_TICK = 64,
    parameter int OVERSAMPLE    = 13,
    parameter int MAJ_LO        = 4,
    parameter int MAJ_HI        = 8
) (
    input  logic              uart_clk,
    input  logic              reset,
    input  logic              i_rx,
    output logic [DATA_W-1:0] o_byte,
    output logic              o_byte_valid
);
    localparam int DIV_W  = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
    localparam int SMP_W  = $clog2(OVERSAMPLE);
    localparam int VOTE_N = MAJ_HI - MAJ_LO + 1;   // samples in the vote window
    localparam int ONES_W = $clog2(VOTE_N + 1);
    localparam int BIT_W  = $clog2(DATA_W);

    logic [DIV_W-1:0]  div_cnt;   // oversample tick divider
    logic              tick;
    logic [1:0]        rx_sync;   // two-flop synchronizer, [1] is the safe copy
    rx_state_t         state;
    logic [SMP_W-1:0]  smp_cnt;   // sample position inside the current bit
    logic [ONES_W-1:0] ones;      // high samples seen inside the window so far
    logic [ONES_W-1:0] ones_nxt;
    logic              in_win;
    logic              bit_val;   // majority decision for the current bit
    logic              bit_end;
    logic [BIT_W-1:0]  bit_idx;
    logic [DATA_W-1:0] shift;

    always_ff @(posedge uart_clk) begin
        if (reset || tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end
    assign tick = (div_cnt == DIV_W'(CLKS_PER_TICK - 1));

    always_ff @(posedge uart_clk) begin
        if (reset)
            rx_sync <= 2'b11;                  // line idles high
        else
            rx_sync <= {rx_sync[0], i_rx};
    end

    // vote bookkeeping, only meaningful outside idle
    assign in_win   = (smp_cnt >= SMP_W'(MAJ_LO)) && (smp_cnt <= SMP_W'(MAJ_HI));
    assign ones_nxt = ones + ONES_W'(in_win && rx_sync[1]);
    assign bit_val  = (ones_nxt > ONES_W'(VOTE_N / 2));
    assign bit_end  = (smp_cnt == SMP_W'(OVERSAMPLE - 1));

    always_ff @(posedge uart_clk) begin
        if (reset) begin
            state        <= IDLE;
            smp_cnt      <= '0;
            ones         <= '0;
            bit_idx      <= '0;
            o_byte_valid <= 1'b0;
        end else begin
            o_byte_valid <= 1'b0;              // single-cycle strobe
            if (tick) begin
                if (state == IDLE) begin
                    smp_cnt <= SMP_W'(1);      // the detecting tick is sample 0
                    ones    <= '0;
                    if (!rx_sync[1])
                        state <= START;
                end else if (bit_end) begin
                    smp_cnt <= '0;
                    ones    <= '0;
                    case (state)
                        START: begin
                            bit_idx <= '0;
                            state   <= bit_val ? IDLE : DATA;  // glitch, not a start bit
                        end
                        DATA: begin
                            bit_idx <= bit_idx + 1'b1;
                            if (bit_idx == BIT_W'(DATA_W - 1))
                                state <= STOP;
                        end
                        STOP: begin
                            o_byte_valid <= bit_val;  // framing error drops the byte
                            state        <= IDLE;
                        end
                        default: state <= IDLE;
                    endcase
                end else begin
                    smp_cnt <= smp_cnt + 1'b1;
                    ones    <= ones_nxt;
                end
            end
        end
    end

    // data path, lsb arrives first so shift in from the top
    always_ff @(posedge uart_clk) begin
        if (tick && bit_end && state == DATA)
            shift <= {bit_val, shift[DATA_W-1:1]};
        if (tick && bit_end && state == STOP)
            o_byte <= shift;
    end

endmodule

//--- design/matrix_loader.sv
module matrix_loader import mm_pkg::*; (
    input  logic              uart_clk,
    input  logic              reset,
    input  logic [DATA_W-1:0] i_byte,
    input  logic              i_byte_valid,
    input  logic              i_stream_end,
    output logic              o_wr_en,
    output logic              o_wr_sel_b,   // 0 = a bank, 1 = b bank
    output logic [IDX_W-1:0]  o_wr_bank,
    output logic [IDX_W-1:0]  o_wr_addr,
    output logic [DATA_W-1:0] o_wr_data,
    output logic              o_start,
    output logic              o_done
);
    localparam int LAST       = N_DIM * N_DIM - 1;
    localparam int DRAIN_W    = $clog2(2 * N_DIM);
    localparam int DRAIN_LAST = 2 * N_DIM - 2;   // 2n-1 cycles after stream end

    job_state_t           state;
    logic [RES_ADR_W-1:0] cnt;          // element index inside the current matrix
    logic                 cnt_last;
    logic                 draining;
    logic [DRAIN_W-1:0]   drain_cnt;

    assign cnt_last = (cnt == RES_ADR_W'(LAST));
    assign o_done   = (state == DONE);

    always_ff @(posedge uart_clk) begin
        if (reset) begin
            state     <= LOAD_A;
            cnt       <= '0;
            o_wr_en   <= 1'b0;
            o_start   <= 1'b0;
            draining  <= 1'b0;
            drain_cnt <= '0;
        end else begin
            o_wr_en <= 1'b0;
            o_start <= (state == COMPUTE) && o_wr_en;   // the last b write is under way
            case (state)
                LOAD_A, DONE: if (i_byte_valid) begin   // a byte in DONE starts a new job
                    o_wr_en <= 1'b1;
                    cnt     <= cnt_last ? '0 : cnt + 1'b1;
                    state   <= cnt_last ? LOAD_B : LOAD_A;
                end
                LOAD_B: if (i_byte_valid) begin
                    o_wr_en <= 1'b1;
                    cnt     <= cnt_last ? '0 : cnt + 1'b1;
                    if (cnt_last)
                        state <= COMPUTE;
                end
                COMPUTE: begin
                    if (i_stream_end) begin
                        draining  <= 1'b1;
                        drain_cnt <= '0;
                    end else if (draining) begin
                        drain_cnt <= drain_cnt + 1'b1;
                        if (drain_cnt == DRAIN_W'(DRAIN_LAST)) begin
                            draining <= 1'b0;
                            state    <= DONE;
                        end
                    end
                end
                default: state <= LOAD_A;
            endcase
        end
    end

    // a is stored by row, b by column
    always_ff @(posedge uart_clk) begin
        if (i_byte_valid) begin
            o_wr_data  <= i_byte;
            o_wr_sel_b <= (state == LOAD_B);
            o_wr_bank  <= (state == LOAD_B) ? IDX_W'(cnt % N_DIM) : IDX_W'(cnt / N_DIM);
            o_wr_addr  <= (state == LOAD_B) ? IDX_W'(cnt / N_DIM) : IDX_W'(cnt % N_DIM);
        end
    end

endmodule

//--- design/operand_skew_buffer.sv
module operand_skew_buffer import mm_pkg::*; (
    input  logic                      uart_clk,
    input  logic                      reset,
    input  logic                      i_wr_en,
    input  logic                      i_wr_sel_b,
    input  logic [IDX_W-1:0]          i_wr_bank,
    input  logic [IDX_W-1:0]          i_wr_addr,
    input  logic [DATA_W-1:0]         i_wr_data,
    input  logic                      i_start,
    output logic [N_DIM*DATA_W-1:0]   o_a_west,    // row i in slice i
    output logic [N_DIM*DATA_W-1:0]   o_b_north,   // column j in slice j
    output logic                      o_clear,
    output logic                      o_stream_end
);
    localparam int STEPS  = 3 * N_DIM - 2;
    localparam int STEP_W = $clog2(STEPS);

    logic [DATA_W-1:0] a_bank [N_DIM][N_DIM];   // [row][k]
    logic [DATA_W-1:0] b_bank [N_DIM][N_DIM];   // [col][k]
    logic              streaming;
    logic [STEP_W-1:0] step;

    always_ff @(posedge uart_clk) begin
        if (i_wr_en && !i_wr_sel_b)
            a_bank[i_wr_bank][i_wr_addr] <= i_wr_data;
        if (i_wr_en && i_wr_sel_b)
            b_bank[i_wr_bank][i_wr_addr] <= i_wr_data;
    end

    // step counter, first step the cycle after start
    always_ff @(posedge uart_clk) begin
        if (reset) begin
            streaming    <= 1'b0;
            step         <= '0;
            o_stream_end <= 1'b0;
        end else begin
            o_stream_end <= streaming && (step == STEP_W'(STEPS - 1));
            if (i_start) begin
                streaming <= 1'b1;
                step      <= '0;
            end else if (streaming) begin
                step <= step + 1'b1;
                if (step == STEP_W'(STEPS - 1))
                    streaming <= 1'b0;
            end
        end
    end

    assign o_clear = streaming && (step == '0);   // lines up with step 0

    // lane i is delayed by i steps, zero outside the valid k range
    always_comb begin
        for (int i = 0; i < N_DIM; i++) begin
            o_a_west[i*DATA_W +: DATA_W]  = '0;
            o_b_north[i*DATA_W +: DATA_W] = '0;
            if (streaming && (step >= i) && (step < i + N_DIM)) begin
                o_a_west[i*DATA_W +: DATA_W]  = a_bank[i][IDX_W'(step - i)];
                o_b_north[i*DATA_W +: DATA_W] = b_bank[i][IDX_W'(step - i)];
            end
        end
    end

endmodule

//--- design/mac_pe.sv
module mac_pe import mm_pkg::*; (
    input  logic              uart_clk,
    input  logic              reset,
    input  logic              i_clear,
    input  logic [DATA_W-1:0] i_a,
    input  logic [DATA_W-1:0] i_b,
    output logic [DATA_W-1:0] o_a,     // to the east neighbour
    output logic [DATA_W-1:0] o_b,     // to the south neighbour
    output logic [ACC_W-1:0]  o_acc
);
    logic [2*DATA_W-1:0] prod;

    assign prod = i_a * i_b;   // full-width unsigned product

    always_ff @(posedge uart_clk) begin
        if (reset) begin
            o_a   <= '0;
            o_b   <= '0;
            o_acc <= '0;
        end else begin
            o_a <= i_a;
            o_b <= i_b;
            // clear loads instead of adding, so k = 0 is kept
            if (i_clear)
                o_acc <= ACC_W'(prod);
            else
                o_acc <= o_acc + ACC_W'(prod);
        end
    end

endmodule

//--- design/systolic_array.sv
module systolic_array import mm_pkg::*; (
    input  logic                          uart_clk,
    input  logic                          reset,
    input  logic                          i_clear,
    input  logic [N_DIM*DATA_W-1:0]       i_a_west,
    input  logic [N_DIM*DATA_W-1:0]       i_b_north,
    output logic [N_DIM*N_DIM*ACC_W-1:0]  o_c          // row-major, word i*n+j
);
    logic [DATA_W-1:0]    a_in [N_DIM][N_DIM];   // operand entering cell (i,j) from the west
    logic [DATA_W-1:0]    b_in [N_DIM][N_DIM];   // operand entering cell (i,j) from the north
    logic [2*N_DIM-3:0]   clear_q;                // bit d-1 is clear delayed by d cycles

    // cell (i,j) sees k = 0 at step i+j
    always_ff @(posedge uart_clk) begin
        if (reset)
            clear_q <= '0;
        else
            clear_q <= {clear_q[2*N_DIM-4:0], i_clear};
    end

    for (genvar i = 0; i < N_DIM; i++) begin : g_row
        assign a_in[i][0] = i_a_west[i*DATA_W +: DATA_W];
        assign b_in[0][i] = i_b_north[i*DATA_W +: DATA_W];

        for (genvar j = 0; j < N_DIM; j++) begin : g_col
            logic [DATA_W-1:0] a_out;
            logic [DATA_W-1:0] b_out;
            logic              pe_clear;

            if (i + j == 0) begin : g_clr0
                assign pe_clear = i_clear;
            end else begin : g_clrd
                assign pe_clear = clear_q[i+j-1];
            end

            if (j < N_DIM - 1) begin : g_east
                assign a_in[i][j+1] = a_out;
            end
            if (i < N_DIM - 1) begin : g_south
                assign b_in[i+1][j] = b_out;
            end

            mac_pe u_pe (
                .uart_clk (uart_clk),
                .reset    (reset),
                .i_clear  (pe_clear),
                .i_a      (a_in[i][j]),
                .i_b      (b_in[i][j]),
                .o_a      (a_out),
                .o_b      (b_out),
                .o_acc    (o_c[(i*N_DIM+j)*ACC_W +: ACC_W])
            );
        end
    end

endmodule

//--- design/result_wb_slave.sv
module result_wb_slave import mm_pkg::*; (
    input  logic                          uart_clk,
    input  logic                          reset,
    input  logic [N_DIM*N_DIM*ACC_W-1:0]  i_c,
    input  logic                          i_wb_cyc,
    input  logic                          i_wb_stb,
    input  logic                          i_wb_we,
    input  logic [RES_ADR_W-1:0]          i_wb_adr,
    output logic [ACC_W-1:0]              o_wb_dat,
    output logic                          o_wb_ack
);
    logic req;

    // new request only when the previous ack has gone
    assign req = i_wb_cyc && i_wb_stb && !o_wb_ack;

    always_ff @(posedge uart_clk) begin
        if (reset)
            o_wb_ack <= 1'b0;
        else
            o_wb_ack <= req;   // one cycle, reads and writes alike
    end

    // nothing is writable, a write only gets its ack
    always_ff @(posedge uart_clk) begin
        if (req && !i_wb_we)
            o_wb_dat <= i_c[i_wb_adr*ACC_W +: ACC_W];
    end

endmodule

//--- design/mm_uart_top.sv
module mm_uart_top import mm_pkg::*; #(
    parameter int CLKS_PER_TICK = 64,
    parameter int OVERSAMPLE    = 13,
    parameter int MAJ_LO        = 4,
    parameter int MAJ_HI        = 8
) (
    input  logic                 uart_clk,
    input  logic                 reset,
    input  logic                 i_uart_rx,
    input  logic                 i_wb_cyc,
    input  logic                 i_wb_stb,
    input  logic                 i_wb_we,
    input  logic [RES_ADR_W-1:0] i_wb_adr,
    output logic [ACC_W-1:0]     o_wb_dat,
    output logic                 o_wb_ack,
    output logic                 o_done
);
    logic [DATA_W-1:0]               rx_byte;
    logic                            rx_valid;
    logic                            wr_en;
    logic                            wr_sel_b;
    logic [IDX_W-1:0]                wr_bank;
    logic [IDX_W-1:0]                wr_addr;
    logic [DATA_W-1:0]               wr_data;
    logic                            start;
    logic                            stream_end;
    logic                            clear;
    logic [N_DIM*DATA_W-1:0]         a_west;
    logic [N_DIM*DATA_W-1:0]         b_north;
    logic [N_DIM*N_DIM*ACC_W-1:0]    c_flat;

    uart_rx #(
        .CLKS_PER_TICK (CLKS_PER_TICK),
        .OVERSAMPLE    (OVERSAMPLE),
        .MAJ_LO        (MAJ_LO),
        .MAJ_HI        (MAJ_HI)
    ) u_rx (
        .uart_clk (uart_clk), .reset (reset), .i_rx (i_uart_rx),
        .o_byte (rx_byte), .o_byte_valid (rx_valid)
    );

    matrix_loader u_loader (
        .uart_clk (uart_clk), .reset (reset),
        .i_byte (rx_byte), .i_byte_valid (rx_valid), .i_stream_end (stream_end),
        .o_wr_en (wr_en), .o_wr_sel_b (wr_sel_b), .o_wr_bank (wr_bank),
        .o_wr_addr (wr_addr), .o_wr_data (wr_data),
        .o_start (start), .o_done (o_done)
    );

    operand_skew_buffer u_skew (
        .uart_clk (uart_clk), .reset (reset),
        .i_wr_en (wr_en), .i_wr_sel_b (wr_sel_b), .i_wr_bank (wr_bank),
        .i_wr_addr (wr_addr), .i_wr_data (wr_data), .i_start (start),
        .o_a_west (a_west), .o_b_north (b_north),
        .o_clear (clear), .o_stream_end (stream_end)
    );

    systolic_array u_array (
        .uart_clk (uart_clk), .reset (reset), .i_clear (clear),
        .i_a_west (a_west), .i_b_north (b_north), .o_c (c_flat)
    );

    result_wb_slave u_wb (
        .uart_clk (uart_clk), .reset (reset), .i_c (c_flat),
        .i_wb_cyc (i_wb_cyc), .i_wb_stb (i_wb_stb), .i_wb_we (i_wb_we),
        .i_wb_adr (i_wb_adr), .o_wb_dat (o_wb_dat), .o_wb_ack (o_wb_ack)
    );

endmodule

//--- tb/tb_mm_uart.sv
module tb_mm_uart import mm_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BIT_CYCLES      = 13 * 4;        // oversample ticks x clocks per tick
    localparam int JOB_BYTES       = 2 * N_DIM * N_DIM;
    localparam int BYTES_TOTAL     = 161;           // 5 jobs plus one framing-error byte
    localparam int WATCHDOG_CYCLES = BYTES_TOTAL * 10 * BIT_CYCLES + 2000;

    logic                 uart_clk;
    logic                 reset;
    logic                 rx_line;                  // serial line, idle high
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [RES_ADR_W-1:0] wb_adr;
    logic [ACC_W-1:0]     wb_dat;
    logic                 wb_ack;
    logic                 done;

    logic [DATA_W-1:0]    mat_a [N_DIM][N_DIM];     // operands of the job in flight
    logic [DATA_W-1:0]    mat_b [N_DIM][N_DIM];
    logic [31:0]          lcg_state;
    int                   n_checks;
    int                   n_errors;

    mm_uart_top #(.CLKS_PER_TICK(4)) UUT (
        .uart_clk (uart_clk), .reset (reset), .i_uart_rx (rx_line),
        .i_wb_cyc (wb_cyc), .i_wb_stb (wb_stb), .i_wb_we (wb_we), .i_wb_adr (wb_adr),
        .o_wb_dat (wb_dat), .o_wb_ack (wb_ack), .o_done (done)
    );

    initial begin
        uart_clk = 1'b0;
        forever #50 uart_clk = ~uart_clk;           // 100 ns period
    end

    // budget covers every byte plus slack for reads and drains
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge uart_clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic [DATA_W-1:0] rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];                    // upper bits have the longer period
    endfunction

    // byte n of a job, a then b, both row-major
    function automatic logic [DATA_W-1:0] job_byte(input int n);
        if (n < N_DIM * N_DIM)
            return mat_a[n / N_DIM][n % N_DIM];
        return mat_b[(n - N_DIM * N_DIM) / N_DIM][(n - N_DIM * N_DIM) % N_DIM];
    endfunction

    task automatic compare_word(input string name, input logic [ACC_W-1:0] got, want);
        n_checks++;
        assert (got === want) else begin
            $display("Mismatch %s: expected %h, got %h", name, want, got);
            n_errors++;
        end
    endtask

    // start bit, 8 data bits lsb first, then the chosen stop level
    task automatic send_byte(input logic [DATA_W-1:0] value, input logic stop_level);
        logic [9:0] frame;
        frame = {stop_level, value, 1'b0};
        for (int k = 0; k < 10; k++) begin
            rx_line = frame[k];
            repeat (BIT_CYCLES) @(negedge uart_clk);
        end
        rx_line = 1'b1;
    endtask

    task automatic send_matrices();
        for (int n = 0; n < JOB_BYTES; n++)
            send_byte(job_byte(n), 1'b1);
    endtask

    task automatic fill_random();
        for (int i = 0; i < N_DIM; i++)
            for (int j = 0; j < N_DIM; j++) begin
                mat_a[i][j] = rand_byte();
                mat_b[i][j] = rand_byte();
            end
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (!done && waited < 200) begin
            @(negedge uart_clk);
            waited++;
        end
        n_checks++;
        assert (done) else begin
            $display("o_done did not rise after the last byte of the job");
            n_errors++;
        end
    endtask

    // one classic cycle with stb held through the ack cycle, so ack has to fall by itself
    task automatic bus_cycle(input logic we, input logic [RES_ADR_W-1:0] adr,
                             output logic [ACC_W-1:0] dat);
        int   waited;
        logic acked;
        waited = 0;
        acked  = 1'b0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = adr;
        while (!acked && waited < 8) begin
            @(negedge uart_clk);
            waited++;
            acked = wb_ack;
        end
        dat = wb_dat;                               // valid while ack is high
        n_checks++;
        assert (acked && waited == 1) else begin
            $display("Wishbone ack for address %0d missing or late (%0d cycles)", adr, waited);
            n_errors++;
        end
        @(negedge uart_clk);                        // request still up here
        n_checks++;
        assert (!wb_ack) else begin
            $display("Wishbone ack stayed high longer than one cycle");
            n_errors++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [RES_ADR_W-1:0] adr, output logic [ACC_W-1:0] dat);
        bus_cycle(1'b0, adr, dat);
    endtask

    task automatic wb_write(input logic [RES_ADR_W-1:0] adr);
        logic [ACC_W-1:0] ignored;
        bus_cycle(1'b1, adr, ignored);
    endtask

    // every word against a 32-bit reference product
    task automatic check_result();
        logic [ACC_W-1:0] want;
        logic [ACC_W-1:0] got;
        for (int i = 0; i < N_DIM; i++)
            for (int j = 0; j < N_DIM; j++) begin
                want = '0;
                for (int k = 0; k < N_DIM; k++)
                    want += ACC_W'(mat_a[i][k]) * ACC_W'(mat_b[k][j]);
                wb_read(RES_ADR_W'(i * N_DIM + j), got);
                compare_word($sformatf("o_wb_dat[%0d]", i * N_DIM + j), got, want);
            end
    endtask

    task automatic after_reset();
        logic [ACC_W-1:0] got;
        compare_word("o_done", ACC_W'(done), '0);
        for (int n = 0; n < N_DIM * N_DIM; n++) begin
            wb_read(RES_ADR_W'(n), got);
            compare_word($sformatf("o_wb_dat[%0d]", n), got, '0);   // accumulators cleared
        end
    endtask

    task automatic identity_job();
        logic [ACC_W-1:0] got;
        for (int i = 0; i < N_DIM; i++)
            for (int j = 0; j < N_DIM; j++) begin
                mat_a[i][j] = (i == j) ? 8'd1 : 8'd0;
                mat_b[i][j] = rand_byte();
            end
        send_matrices();
        wait_done();
        for (int i = 0; i < N_DIM; i++)
            for (int j = 0; j < N_DIM; j++) begin
                wb_read(RES_ADR_W'(i * N_DIM + j), got);
                compare_word($sformatf("o_wb_dat[%0d]", i * N_DIM + j), got,
                             ACC_W'(mat_b[i][j]));
            end
    endtask

    task automatic random_jobs();
        fill_random();
        send_matrices();
        wait_done();
        check_result();
        for (int i = 0; i < N_DIM; i++)
            for (int j = 0; j < N_DIM; j++) begin
                mat_a[i][j] = 8'hff;                 // largest possible sums must not wrap
                mat_b[i][j] = 8'hff;
            end
        send_matrices();
        wait_done();
        check_result();
    endtask

    task automatic restart_after_done();
        int waited;
        fill_random();
        compare_word("o_done", ACC_W'(done), 32'h1);
        send_byte(job_byte(0), 1'b1);
        waited = 0;
        while (done && waited < BIT_CYCLES) begin   // drop follows the stop sample
            @(negedge uart_clk);
            waited++;
        end
        compare_word("o_done", ACC_W'(done), '0);
        for (int n = 1; n < JOB_BYTES; n++)
            send_byte(job_byte(n), 1'b1);
        wait_done();
        check_result();
    endtask

    task automatic framing_error_job();
        fill_random();
        for (int n = 0; n < JOB_BYTES; n++) begin
            if (n == 7)
                send_byte(8'ha5, 1'b0);             // low stop bit drops this byte
            send_byte(job_byte(n), 1'b1);
        end
        wait_done();
        check_result();
    endtask

    task automatic bus_write_ignored();
        logic [ACC_W-1:0] got;
        logic [ACC_W-1:0] want;
        want = '0;
        for (int k = 0; k < N_DIM; k++)
            want += ACC_W'(mat_a[1][k]) * ACC_W'(mat_b[k][1]);   // word 5 is c[1][1]
        wb_write(RES_ADR_W'(5));
        wb_read(RES_ADR_W'(5), got);
        compare_word("o_wb_dat[5]", got, want);
    endtask

    initial begin
        reset     = 1'b1;
        rx_line   = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        lcg_state = 32'h5682;
        n_checks  = 0;
        n_errors  = 0;
        repeat (3) @(negedge uart_clk);
        reset = 1'b0;
        @(negedge uart_clk);
        after_reset();
        identity_job();
        random_jobs();
        restart_after_done();
        framing_error_job();
        bus_write_ignored();
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- verilog.f
design/mm_pkg.sv
design/uart_rx.sv
design/matrix_loader.sv
design/operand_skew_buffer.sv
design/mac_pe.sv
design/systolic_array.sv
design/result_wb_slave.sv
design/mm_uart_top.sv
tb/tb_mm_uart.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run tb_mm_uart with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mm_uart \
    -f verilog.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_mm_uart > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0
